/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

    // Integer register width of the core
    localparam int xlen = 64;

    typedef logic [4:0] reg_idx_t;
    typedef logic [xlen-1:0] xword_t;

    // Which pipe an instruction belongs to
    typedef enum logic [2:0] {
        op_int    = 3'd0,
        op_load   = 3'd1,
        op_store  = 3'd2,
        op_muldiv = 3'd3
    } op_class_e;

    // First operand source
    typedef enum logic [1:0] {
        opr1_rs1  = 2'd0,
        opr1_pc   = 2'd1,
        opr1_zero = 2'd2,
        opr1_zimm = 2'd3
    } opr1_sel_e;

    // Second operand source with code 3 left unused
    typedef enum logic [1:0] {
        opr2_rs2  = 2'd0,
        opr2_imm  = 2'd1,
        opr2_four = 2'd2
    } opr2_sel_e;

    typedef enum logic [1:0] {
        mem_byte   = 2'd0,
        mem_half   = 2'd1,
        mem_word   = 2'd2,
        mem_double = 2'd3
    } mem_width_e;

endpackage

/* hdl/issue_pkg.sv */
package issue_pkg;

    // Instruction as handed over by decode
    typedef struct packed {
        rv_isa_pkg::xword_t     pc;
        rv_isa_pkg::xword_t     imm;
        rv_isa_pkg::reg_idx_t   rs1;
        rv_isa_pkg::reg_idx_t   rs2;
        rv_isa_pkg::reg_idx_t   rd;
        logic                   wb_en;
        rv_isa_pkg::op_class_e  op_class;
        rv_isa_pkg::opr1_sel_e  opr1_sel;
        rv_isa_pkg::opr2_sel_e  opr2_sel;
        logic [3:0]             alu_op;
        logic                   option;
        logic                   truncate;
        logic                   mem_sign;
        rv_isa_pkg::mem_width_e mem_width;
        logic [2:0]             md_op;
        logic                   muldiv;
    } decoded_instr_t;

    // One forwarding or stall point
    typedef struct packed {
        logic                 valid;
        rv_isa_pkg::reg_idx_t dst;
        rv_isa_pkg::xword_t   value;
    } bypass_tap_t;

    // Load/store memory stage
    typedef struct packed {
        logic                 busy_wb_en;
        rv_isa_pkg::reg_idx_t dst;
        rv_isa_pkg::xword_t   result;
        logic                 result_valid;
    } mem_tap_t;

    typedef struct packed {
        rv_isa_pkg::xword_t   pc;
        rv_isa_pkg::reg_idx_t dst;
        logic                 wb_en;
        logic [3:0]           alu_op;
        logic                 option;
        logic                 truncate;
        rv_isa_pkg::xword_t   operand1;
        rv_isa_pkg::xword_t   operand2;
    } int_req_t;

    typedef struct packed {
        rv_isa_pkg::xword_t     pc;
        rv_isa_pkg::reg_idx_t   dst;
        logic                   wb_en;
        rv_isa_pkg::xword_t     base;
        logic [11:0]            offset;
        rv_isa_pkg::xword_t     source;
        logic                   mem_sign;
        rv_isa_pkg::mem_width_e mem_width;
    } lsp_req_t;

    typedef struct packed {
        rv_isa_pkg::xword_t   pc;
        rv_isa_pkg::reg_idx_t dst;
        rv_isa_pkg::xword_t   operand1;
        rv_isa_pkg::xword_t   operand2;
        logic [2:0]           md_op;
        logic                 muldiv;
    } md_req_t;

    // At most one strobe per cycle
    typedef struct packed {
        logic to_int;
        logic to_lsp;
        logic to_md;
    } issue_sel_t;

endpackage

/* hdl/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass #(
    parameter bit enable_mem_fwd = 1'b0
) (
    input  rv_isa_pkg::reg_idx_t  src,
    input  rv_isa_pkg::xword_t    rf_data,
    input  issue_pkg::bypass_tap_t wbuf_tap,
    input  issue_pkg::bypass_tap_t ip_wb_tap,
    input  issue_pkg::bypass_tap_t lsp_wb_tap,
    input  issue_pkg::bypass_tap_t ip_ex_tap,
    input  logic                  ip_ex_stalled,
    input  issue_pkg::mem_tap_t   lsp_mem,
    input  issue_pkg::bypass_tap_t lsp_ag_tap,
    input  issue_pkg::bypass_tap_t md_issue_tap,
    input  issue_pkg::bypass_tap_t md_active_tap,
    output rv_isa_pkg::xword_t    value,
    output logic                  ready
);
    import rv_isa_pkg::*;
    import issue_pkg::*;

    function automatic logic tap_hit(input bypass_tap_t tap, input reg_idx_t idx);
        return tap.valid && (tap.dst == idx);
    endfunction

    // Walk from the oldest producer to the youngest so the newest value wins
    always_comb begin
        value = rf_data;
        ready = 1'b1;

        if (tap_hit(wbuf_tap, src)) begin
            value = wbuf_tap.value;
            ready = 1'b1;
        end
        if (tap_hit(ip_wb_tap, src)) begin
            value = ip_wb_tap.value;
            ready = 1'b1;
        end
        // Integer execute result forwards only once the pipe took the instruction
        if (tap_hit(ip_ex_tap, src)) begin
            value = ip_ex_tap.value;
            ready = 1'b1;
        end
        if (ip_ex_stalled && (ip_ex_tap.dst == src)) begin
            ready = 1'b0;
        end

        if (tap_hit(lsp_wb_tap, src)) begin
            value = lsp_wb_tap.value;
            ready = 1'b1;
        end
        // A load in the memory stage stalls unless its readout is forwarded early
        if (lsp_mem.busy_wb_en && (lsp_mem.dst == src)) begin
            ready = 1'b0;
            if (enable_mem_fwd && lsp_mem.result_valid) begin
                value = lsp_mem.result;
                ready = 1'b1;
            end
        end
        if (tap_hit(lsp_ag_tap, src)) begin
            ready = 1'b0;
        end

        // Muldiv results only come back through writeback
        if (tap_hit(md_issue_tap, src)) begin
            ready = 1'b0;
        end
        if (tap_hit(md_active_tap, src)) begin
            ready = 1'b0;
        end

        // x0 wins even over a stray write to x0 on any tap
        if (src == '0) begin
            value = '0;
            ready = 1'b1;
        end
    end

endmodule

/* hdl/issue_control.sv */
`timescale 1ns/1ps

module issue_control #(
    parameter bit enable_mem_fwd = 1'b0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pipe_flush,
    input  issue_pkg::decoded_instr_t dec_instr,
    input  logic                      dec_valid,
    output logic                      dec_ready,
    output rv_isa_pkg::reg_idx_t      rf_src0,
    output rv_isa_pkg::reg_idx_t      rf_src1,
    input  rv_isa_pkg::xword_t        rf_data0,
    input  rv_isa_pkg::xword_t        rf_data1,
    input  issue_pkg::bypass_tap_t    wbuf_tap,
    input  issue_pkg::bypass_tap_t    ip_wb_tap,
    input  issue_pkg::bypass_tap_t    lsp_wb_tap,
    input  issue_pkg::bypass_tap_t    ip_fwd_value,
    input  issue_pkg::bypass_tap_t    md_active_tap,
    input  issue_pkg::mem_tap_t       lsp_mem,
    input  issue_pkg::int_req_t       int_req,
    input  logic                      int_valid,
    input  issue_pkg::lsp_req_t       lsp_req,
    input  logic                      lsp_valid,
    input  issue_pkg::md_req_t        md_req,
    input  logic                      md_valid,
    input  logic                      int_ready,
    input  logic                      lsp_ready,
    input  logic                      md_ready,
    output issue_pkg::issue_sel_t     issue,
    output rv_isa_pkg::xword_t        operand1,
    output rv_isa_pkg::xword_t        operand2
);
    import rv_isa_pkg::*;
    import issue_pkg::*;

    bypass_tap_t ip_ex_tap;
    bypass_tap_t lsp_ag_tap;
    bypass_tap_t md_issue_tap;
    logic        ip_ex_stalled;
    xword_t      rs1_value;
    xword_t      rs2_value;
    logic        rs1_ready;
    logic        rs2_ready;
    logic        out_of_reset;
    logic        ip_busy_rd;
    logic        lsp_busy_rd;
    logic        md_busy_rd;
    logic        opr_ready;
    logic        issue_ok;
    logic        any_issue;

    assign rf_src0 = dec_instr.rs1;
    assign rf_src1 = dec_instr.rs2;

    // Stall points rebuilt from what sits in the issue registers
    assign ip_ex_tap     = '{valid: int_valid && int_ready && int_req.wb_en,
                             dst: int_req.dst, value: ip_fwd_value.value};
    assign ip_ex_stalled = int_valid && !int_ready && int_req.wb_en;
    assign lsp_ag_tap    = '{valid: lsp_valid && lsp_req.wb_en, dst: lsp_req.dst, value: '0};
    assign md_issue_tap  = '{valid: md_valid, dst: md_req.dst, value: '0};

    operand_bypass #(.enable_mem_fwd(enable_mem_fwd)) u_bypass_rs1 (
        .src(dec_instr.rs1), .rf_data(rf_data0),
        .wbuf_tap(wbuf_tap), .ip_wb_tap(ip_wb_tap), .lsp_wb_tap(lsp_wb_tap),
        .ip_ex_tap(ip_ex_tap), .ip_ex_stalled(ip_ex_stalled), .lsp_mem(lsp_mem),
        .lsp_ag_tap(lsp_ag_tap), .md_issue_tap(md_issue_tap),
        .md_active_tap(md_active_tap), .value(rs1_value), .ready(rs1_ready)
    );

    operand_bypass #(.enable_mem_fwd(enable_mem_fwd)) u_bypass_rs2 (
        .src(dec_instr.rs2), .rf_data(rf_data1),
        .wbuf_tap(wbuf_tap), .ip_wb_tap(ip_wb_tap), .lsp_wb_tap(lsp_wb_tap),
        .ip_ex_tap(ip_ex_tap), .ip_ex_stalled(ip_ex_stalled), .lsp_mem(lsp_mem),
        .lsp_ag_tap(lsp_ag_tap), .md_issue_tap(md_issue_tap),
        .md_active_tap(md_active_tap), .value(rs2_value), .ready(rs2_ready)
    );

    always_comb begin
        case (dec_instr.opr1_sel)
            opr1_rs1:  operand1 = rs1_value;
            opr1_pc:   operand1 = dec_instr.pc;
            opr1_zero: operand1 = '0;
            opr1_zimm: operand1 = xword_t'(dec_instr.rs1);
        endcase
        case (dec_instr.opr2_sel)
            opr2_rs2:  operand2 = rs2_value;
            opr2_imm:  operand2 = dec_instr.imm;
            opr2_four: operand2 = xword_t'(4);
            default:   operand2 = '0;
        endcase
    end

    assign opr_ready = ((dec_instr.opr1_sel != opr1_rs1) || rs1_ready) &&
                       ((dec_instr.opr2_sel != opr2_rs2) || rs2_ready);

    // Pending writers of rd grouped by pipe
    assign ip_busy_rd  = (ip_wb_tap.valid && (ip_wb_tap.dst == dec_instr.rd)) ||
                         (int_valid && int_req.wb_en && (int_req.dst == dec_instr.rd));
    assign lsp_busy_rd = (lsp_mem.busy_wb_en && (lsp_mem.dst == dec_instr.rd)) ||
                         (lsp_ag_tap.valid && (lsp_ag_tap.dst == dec_instr.rd));
    assign md_busy_rd  = (md_issue_tap.valid && (md_issue_tap.dst == dec_instr.rd)) ||
                         (md_active_tap.valid && (md_active_tap.dst == dec_instr.rd));

    always_ff @(posedge clk) begin
        if (rst) begin
            out_of_reset <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
        end
    end

    assign issue_ok = out_of_reset && dec_valid && opr_ready && !pipe_flush;

    // A slower pipe must not retire its write after a younger one to the same rd
    assign issue.to_int = issue_ok && int_ready && (dec_instr.op_class == op_int) &&
                          !(dec_instr.wb_en && (lsp_busy_rd || md_busy_rd));
    assign issue.to_lsp = issue_ok && lsp_ready &&
                          ((dec_instr.op_class == op_load) ||
                           (dec_instr.op_class == op_store)) &&
                          !(dec_instr.wb_en && (ip_busy_rd || md_busy_rd));
    assign issue.to_md  = issue_ok && md_ready && (dec_instr.op_class == op_muldiv) &&
                          !(dec_instr.wb_en && lsp_busy_rd);

    assign any_issue = issue.to_int || issue.to_lsp || issue.to_md;
    assign dec_ready = out_of_reset && !(dec_valid && !any_issue && !pipe_flush);

endmodule

/* hdl/dispatch_regs.sv */
`timescale 1ns/1ps

module dispatch_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pipe_flush,
    input  issue_pkg::decoded_instr_t dec_instr,
    input  issue_pkg::issue_sel_t     issue,
    input  rv_isa_pkg::xword_t        operand1,
    input  rv_isa_pkg::xword_t        operand2,
    output issue_pkg::int_req_t       int_req,
    output issue_pkg::lsp_req_t       lsp_req,
    output issue_pkg::md_req_t        md_req,
    output logic                      int_valid,
    output logic                      lsp_valid,
    output logic                      md_valid,
    input  logic                      int_ready,
    input  logic                      lsp_ready,
    input  logic                      md_ready
);

    // A new issue sets valid and otherwise a take or a flush drops it
    function automatic logic next_valid(input logic valid, input logic load,
                                        input logic ready, input logic flush);
        if (load) begin
            return 1'b1;
        end
        return valid && !(ready || flush);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            int_valid <= 1'b0;
            lsp_valid <= 1'b0;
            md_valid  <= 1'b0;
        end else begin
            int_valid <= next_valid(int_valid, issue.to_int, int_ready, pipe_flush);
            lsp_valid <= next_valid(lsp_valid, issue.to_lsp, lsp_ready, pipe_flush);
            md_valid  <= next_valid(md_valid, issue.to_md, md_ready, pipe_flush);
        end
    end

    always_ff @(posedge clk) begin
        if (issue.to_int) begin
            int_req <= '{pc: dec_instr.pc, dst: dec_instr.rd, wb_en: dec_instr.wb_en,
                         alu_op: dec_instr.alu_op, option: dec_instr.option,
                         truncate: dec_instr.truncate,
                         operand1: operand1, operand2: operand2};
        end
        // Store data rides in source and the address is base plus offset
        if (issue.to_lsp) begin
            lsp_req <= '{pc: dec_instr.pc, dst: dec_instr.rd, wb_en: dec_instr.wb_en,
                         base: operand1, offset: dec_instr.imm[11:0], source: operand2,
                         mem_sign: dec_instr.mem_sign, mem_width: dec_instr.mem_width};
        end
        if (issue.to_md) begin
            md_req <= '{pc: dec_instr.pc, dst: dec_instr.rd,
                        operand1: operand1, operand2: operand2,
                        md_op: dec_instr.md_op, muldiv: dec_instr.muldiv};
        end
    end

    // Back-pressured requests stay put until the pipe takes them
    assert property (@(posedge clk) disable iff (rst)
        int_valid && !int_ready && !pipe_flush |=> int_valid && $stable(int_req))
        else $error("integer request changed under back-pressure");
    assert property (@(posedge clk) disable iff (rst)
        lsp_valid && !lsp_ready && !pipe_flush |=> lsp_valid && $stable(lsp_req))
        else $error("load/store request changed under back-pressure");
    assert property (@(posedge clk) disable iff (rst)
        md_valid && !md_ready && !pipe_flush |=> md_valid && $stable(md_req))
        else $error("muldiv request changed under back-pressure");

endmodule

/* hdl/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage #(
    parameter bit enable_mem_fwd = 1'b0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pipe_flush,
    // Decode side
    input  issue_pkg::decoded_instr_t dec_instr,
    input  logic                      dec_valid,
    output logic                      dec_ready,
    // Register file read ports
    output rv_isa_pkg::reg_idx_t      rf_src0,
    output rv_isa_pkg::reg_idx_t      rf_src1,
    input  rv_isa_pkg::xword_t        rf_data0,
    input  rv_isa_pkg::xword_t        rf_data1,
    // Forwarding and hazard taps
    input  issue_pkg::bypass_tap_t    wbuf_tap,
    input  issue_pkg::bypass_tap_t    ip_wb_tap,
    input  issue_pkg::bypass_tap_t    lsp_wb_tap,
    input  issue_pkg::bypass_tap_t    ip_fwd_value,
    input  issue_pkg::bypass_tap_t    md_active_tap,
    input  issue_pkg::mem_tap_t       lsp_mem,
    // Pipe requests
    output issue_pkg::int_req_t       int_req,
    output logic                      int_valid,
    input  logic                      int_ready,
    output issue_pkg::lsp_req_t       lsp_req,
    output logic                      lsp_valid,
    input  logic                      lsp_ready,
    output issue_pkg::md_req_t        md_req,
    output logic                      md_valid,
    input  logic                      md_ready
);
    import rv_isa_pkg::*;
    import issue_pkg::*;

    issue_sel_t issue;
    xword_t     operand1;
    xword_t     operand2;

    issue_control #(.enable_mem_fwd(enable_mem_fwd)) u_issue_control (
        .clk(clk), .rst(rst), .pipe_flush(pipe_flush),
        .dec_instr(dec_instr), .dec_valid(dec_valid), .dec_ready(dec_ready),
        .rf_src0(rf_src0), .rf_src1(rf_src1), .rf_data0(rf_data0), .rf_data1(rf_data1),
        .wbuf_tap(wbuf_tap), .ip_wb_tap(ip_wb_tap), .lsp_wb_tap(lsp_wb_tap),
        .ip_fwd_value(ip_fwd_value), .md_active_tap(md_active_tap), .lsp_mem(lsp_mem),
        .int_req(int_req), .int_valid(int_valid),
        .lsp_req(lsp_req), .lsp_valid(lsp_valid),
        .md_req(md_req), .md_valid(md_valid),
        .int_ready(int_ready), .lsp_ready(lsp_ready), .md_ready(md_ready),
        .issue(issue), .operand1(operand1), .operand2(operand2)
    );

    dispatch_regs u_dispatch_regs (
        .clk(clk), .rst(rst), .pipe_flush(pipe_flush),
        .dec_instr(dec_instr), .issue(issue),
        .operand1(operand1), .operand2(operand2),
        .int_req(int_req), .lsp_req(lsp_req), .md_req(md_req),
        .int_valid(int_valid), .lsp_valid(lsp_valid), .md_valid(md_valid),
        .int_ready(int_ready), .lsp_ready(lsp_ready), .md_ready(md_ready)
    );

endmodule

/* testbench/issue_checker.sv */
`timescale 1ns/1ps

module issue_checker (
    input  logic                 clk,
    input  logic                 dec_ready,
    input  rv_isa_pkg::reg_idx_t rf_src0,
    input  rv_isa_pkg::reg_idx_t rf_src1,
    input  issue_pkg::int_req_t  int_req,
    input  logic                 int_valid,
    input  issue_pkg::lsp_req_t  lsp_req,
    input  logic                 lsp_valid,
    input  issue_pkg::md_req_t   md_req,
    input  logic                 md_valid,
    input  logic [2:0]           mode,
    input  logic [127:0]         name,
    input  rv_isa_pkg::reg_idx_t exp_rs1,
    input  rv_isa_pkg::reg_idx_t exp_rs2,
    input  rv_isa_pkg::xword_t   exp_op1,
    input  rv_isa_pkg::xword_t   exp_op2,
    input  logic [11:0]          exp_offset,
    output int                   errors
);
    import issue_pkg::*;

    initial begin
        errors = 0;
    end

    task automatic compare(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %0s %0s expected %h actual %h", name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic missing(input string pipe_name);
        $display("%0s: no valid request on the %0s pipe", name, pipe_name);
        errors++;
    endtask

    // Mode 1..3 pick a pipe, 4 expects a stall, 5 expects idle, 6 a held load/store
    always @(posedge clk) begin
        // Register file read addresses follow the sources of the presented instruction
        if (mode != 3'd0) begin
            compare("rf_src0", 64'(exp_rs1), 64'(rf_src0));
            compare("rf_src1", 64'(exp_rs2), 64'(rf_src1));
        end
        case (mode)
            3'd1: begin
                if (!int_valid) begin
                    missing("integer");
                end else begin
                    compare("operand1", exp_op1, int_req.operand1);
                    compare("operand2", exp_op2, int_req.operand2);
                end
            end
            3'd2, 3'd6: begin
                if (!lsp_valid) begin
                    missing("load/store");
                end else begin
                    compare("base", exp_op1, lsp_req.base);
                    compare("source", exp_op2, lsp_req.source);
                    compare("offset", 64'(exp_offset), 64'(lsp_req.offset));
                end
            end
            3'd3: begin
                if (!md_valid) begin
                    missing("muldiv");
                end else begin
                    compare("operand1", exp_op1, md_req.operand1);
                    compare("operand2", exp_op2, md_req.operand2);
                end
            end
            3'd4: begin
                if (dec_ready) begin
                    $display("%0s: decode accepted while the instruction should stall", name);
                    errors++;
                end
            end
            3'd5: begin
                if (int_valid || lsp_valid || md_valid) begin
                    $display("%0s: a pipe valid is still set after the flush", name);
                    errors++;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* testbench/tb_issue_stage.sv */
`timescale 1ns/1ps

module tb_issue_stage;
    import rv_isa_pkg::*;
    import issue_pkg::*;

    localparam logic [63:0] rand_marker = '1;
    localparam int wait_limit = 20;

    logic           clk;
    logic           rst;
    logic           pipe_flush;
    decoded_instr_t dec_instr;
    logic           dec_valid;
    logic           dec_ready;
    reg_idx_t       rf_src0;
    reg_idx_t       rf_src1;
    xword_t         rf_data0;
    xword_t         rf_data1;
    bypass_tap_t    wbuf_tap;
    bypass_tap_t    ip_wb_tap;
    bypass_tap_t    lsp_wb_tap;
    bypass_tap_t    ip_fwd_value;
    bypass_tap_t    md_active_tap;
    mem_tap_t       lsp_mem;
    int_req_t       int_req;
    lsp_req_t       lsp_req;
    md_req_t        md_req;
    logic           int_valid;
    logic           lsp_valid;
    logic           md_valid;
    logic           int_ready;
    logic           lsp_ready;
    logic           md_ready;

    logic [2:0]     check_mode;
    logic [127:0]   name;
    reg_idx_t       exp_rs1;
    reg_idx_t       exp_rs2;
    xword_t         exp_op1;
    xword_t         exp_op2;
    logic [11:0]    exp_offset;
    int             check_errors;
    int             timeouts;
    int             bad_lines;
    int             scenarios;
    logic [63:0]    rng_state;

    // One golden line
    logic [63:0] cls, o1, o2, rs1, rs2, rd, wb, imm, pc, rf0, rf1;
    logic [63:0] taps, tdst, tval, rdy, rdy_after, hold, exp_pipe, exp1, exp2;

    issue_stage dut (.*);

    issue_checker u_checker (
        .clk(clk), .dec_ready(dut.dec_ready),
        .rf_src0(dut.rf_src0), .rf_src1(dut.rf_src1),
        .int_req(dut.int_req), .int_valid(dut.int_valid),
        .lsp_req(dut.lsp_req), .lsp_valid(dut.lsp_valid),
        .md_req(dut.md_req), .md_valid(dut.md_valid),
        .mode(check_mode), .name(name), .exp_rs1(exp_rs1), .exp_rs2(exp_rs2),
        .exp_op1(exp_op1), .exp_op2(exp_op2),
        .exp_offset(exp_offset), .errors(check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    // Taps carry tval plus a per-tap offset so each source is distinguishable
    task automatic drive_taps(input logic [5:0] mask);
        wbuf_tap      <= '{valid: mask[0], dst: reg_idx_t'(tdst), value: tval + 64'd1};
        ip_wb_tap     <= '{valid: mask[1], dst: reg_idx_t'(tdst), value: tval + 64'd2};
        lsp_wb_tap    <= '{valid: mask[2], dst: reg_idx_t'(tdst), value: tval + 64'd3};
        ip_fwd_value  <= '{valid: mask[3], dst: reg_idx_t'(tdst), value: tval + 64'd4};
        md_active_tap <= '{valid: mask[4], dst: reg_idx_t'(tdst), value: '0};
        lsp_mem       <= '{busy_wb_en: mask[5], dst: reg_idx_t'(tdst), result: '0,
                           result_valid: 1'b0};
    endtask

    task automatic wait_accept(output logic ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < wait_limit; n++) begin
            @(negedge clk);
            if (dec_ready) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    task automatic run_scenario;
        logic ok;
        @(posedge clk);
        dec_instr <= '{pc: pc, imm: imm, rs1: reg_idx_t'(rs1), rs2: reg_idx_t'(rs2),
                       rd: reg_idx_t'(rd), wb_en: wb[0], op_class: op_class_e'(cls[2:0]),
                       opr1_sel: opr1_sel_e'(o1[1:0]), opr2_sel: opr2_sel_e'(o2[1:0]),
                       alu_op: 4'd0, option: 1'b0, truncate: 1'b0, mem_sign: 1'b0,
                       mem_width: mem_double, md_op: 3'd0, muldiv: 1'b0};
        rf_data0 <= rf0;
        rf_data1 <= rf1;
        drive_taps(taps[5:0]);
        {int_ready, lsp_ready, md_ready} <= rdy[2:0];
        exp_rs1 <= reg_idx_t'(rs1);
        exp_rs2 <= reg_idx_t'(rs2);
        exp_op1 <= exp1;
        exp_op2 <= exp2;
        exp_offset <= imm[11:0];
        dec_valid <= (exp_pipe <= 64'd2) || (exp_pipe == 64'd4);
        pipe_flush <= (exp_pipe == 64'd3);

        if (exp_pipe == 64'd3) begin
            @(posedge clk);
            pipe_flush <= 1'b0;
            @(negedge clk);
            check_mode <= 3'd5;
        end else if (exp_pipe == 64'd5) begin
            @(negedge clk);
            check_mode <= 3'd6;
        end else begin
            repeat (hold) begin
                @(negedge clk);
                check_mode <= 3'd4;
            end
            if (hold != 0) begin
                @(posedge clk);
                check_mode <= 3'd0;
                // Producer finishes and a load result shows up on writeback
                md_active_tap <= '0;
                lsp_mem <= '0;
                if (taps[5]) begin
                    lsp_wb_tap <= '{valid: 1'b1, dst: reg_idx_t'(tdst), value: tval + 64'd3};
                end
            end
            if (exp_pipe == 64'd4) begin
                dec_valid <= 1'b0;
                return;
            end
            wait_accept(ok);
            if (!ok) begin
                $display("%0s: decode never accepted the instruction", name);
                timeouts++;
                @(posedge clk);
                dec_valid <= 1'b0;
                return;
            end
            @(posedge clk);
            dec_valid <= 1'b0;
            {int_ready, lsp_ready, md_ready} <= rdy_after[2:0];
            // Valid is due one cycle after acceptance
            @(negedge clk);
            check_mode <= 3'(exp_pipe + 64'd1);
        end
        @(posedge clk);
        check_mode <= 3'd0;
    endtask

    initial begin
        string line;
        int    fd;
        int    n;
        rst = 1'b1;
        pipe_flush = 1'b0;
        dec_instr = '0;
        dec_valid = 1'b0;
        rf_data0 = '0;
        rf_data1 = '0;
        wbuf_tap = '0;
        ip_wb_tap = '0;
        lsp_wb_tap = '0;
        ip_fwd_value = '0;
        md_active_tap = '0;
        lsp_mem = '0;
        int_ready = 1'b1;
        lsp_ready = 1'b1;
        md_ready = 1'b1;
        check_mode = 3'd0;
        name = '0;
        exp_rs1 = '0;
        exp_rs2 = '0;
        exp_op1 = '0;
        exp_op2 = '0;
        exp_offset = '0;
        timeouts = 0;
        bad_lines = 0;
        scenarios = 0;
        rng_state = 64'd11;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("testbench/issue_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file");
            bad_lines++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                name, cls, o1, o2, rs1, rs2, rd, wb, imm, pc, rf0, rf1,
                                taps, tdst, tval, rdy, rdy_after, hold, exp_pipe, exp1, exp2);
                    if (n != 21) begin
                        $display("golden line could not be parsed: %0s", line);
                        bad_lines++;
                    end else begin
                        if (rf0 == rand_marker) begin
                            rng_state = xorshift(rng_state);
                            rf0 = rng_state;
                        end
                        if (rf1 == rand_marker) begin
                            rng_state = xorshift(rng_state);
                            rf1 = rng_state;
                        end
                        if (exp1 == rand_marker) begin
                            exp1 = rf0;
                        end
                        if (exp2 == rand_marker) begin
                            exp2 = rf1;
                        end
                        run_scenario();
                        scenarios++;
                    end
                end
            end
            $fclose(fd);
        end

        @(posedge clk);
        $display("scenarios %0d, check errors %0d, timeouts %0d, file errors %0d",
                 scenarios, check_errors, timeouts, bad_lines);
        if (check_errors == 0 && timeouts == 0 && bad_lines == 0 && scenarios > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* testbench/issue_golden.txt */
# name cls o1 o2 rs1 rs2 rd wb imm pc rf0 rf1 taps tdst tval rdy rdy_after hold exp_pipe exp1 exp2
# taps: 1 wbuf, 2 int wb, 4 lsp wb, 8 int fwd, 10 md active, 20 mem busy; all hex, ffffffffffffffff is random
rf_read 0 0 0 03 04 05 1 0 1000 ffffffffffffffff ffffffffffffffff 00 00 0 7 7 0 0 ffffffffffffffff ffffffffffffffff
x0_read 0 0 0 00 04 05 1 0 1004 1234 ffffffffffffffff 03 00 100 7 7 0 0 0 ffffffffffffffff
ex_setup 0 1 2 00 00 07 1 0 2000 0 0 00 00 0 7 3 0 0 2000 4
fwd_ex 0 0 1 07 00 09 1 55 2004 aaaa 0 0b 07 500 7 7 0 0 504 55
fwd_lsp 0 0 2 0a 00 0b 1 0 2008 bbbb 0 05 0a 700 7 7 0 0 703 4
wbuf_fwd 0 0 2 1e 00 1f 1 0 200c cccc 0 01 1e 300 7 7 0 0 301 4
load_use 0 0 0 03 0c 0d 1 0 2010 ffffffffffffffff 0 20 0c 900 7 7 3 0 ffffffffffffffff 903
int_zimm 0 3 1 15 00 0e 1 fff0 2014 0 0 00 00 0 7 7 0 0 15 fff0
load_route 1 0 0 06 08 10 1 abc 2018 1111 2222 00 00 0 7 5 0 1 1111 2222
load_stall 1 0 0 06 08 11 1 10 201c 1111 2222 00 00 0 5 5 3 4 0 0
int_under_bp 0 1 2 00 00 12 1 0 3000 0 0 00 00 0 5 5 0 0 3000 4
lsp_held 0 0 0 00 00 00 0 abc 0 0 0 00 00 0 5 5 0 5 1111 2222
flush_all 0 0 0 00 00 00 0 0 0 0 0 00 00 0 5 7 0 3 0 0
md_route 3 0 0 0e 0f 13 1 0 4000 ffffffffffffffff ffffffffffffffff 00 00 0 7 7 0 2 ffffffffffffffff ffffffffffffffff
waw_md 0 1 2 00 00 14 1 0 4004 0 0 10 14 0 7 7 4 0 4004 4

/* all.f */
hdl/rv_isa_pkg.sv
hdl/issue_pkg.sv
hdl/operand_bypass.sv
hdl/issue_control.sv
hdl/dispatch_regs.sv
hdl/issue_stage.sv
testbench/issue_checker.sv
testbench/tb_issue_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_issue_stage -f all.f -o sim_issue
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi
out=$(./obj_dir/sim_issue)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if printf '%s\n' "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
